// ==== Bender.yml ====
package:
  name: bch_decoder

sources:
  - include_dirs:
      - logic
    files:
      - logic/gfPkg.sv
      - logic/bchPkg.sv
      - logic/gfMultiplier.sv
      - logic/syndromeUnit.sv
      - logic/errorLocator.sv
      - logic/chienSearch.sv
      - logic/bchDecoder.sv
  - target: test
    files:
      - tests/bchDecoderTb.sv

// ==== logic/bchDecoder.sv ====
`default_nettype none

module bchDecoder (
	input logic clk,
	input logic reset,
	input logic inValid,
	input bchPkg::codeword rxWord,
	output logic outValid,
	output bchPkg::decResult result
);
	import bchPkg::*;

	logic synValid;
	synResult synData;
	logic locValid;
	locResult locData;

	// Three-stage pipeline, one word per stage.
	syndromeUnit syndrome (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.rxWord(rxWord),
		.synValid(synValid),
		.synOut(synData)
	);

	errorLocator locator (
		.clk(clk),
		.reset(reset),
		.synValid(synValid),
		.synIn(synData),
		.locValid(locValid),
		.locOut(locData)
	);

	chienSearch search (
		.clk(clk),
		.reset(reset),
		.locValid(locValid),
		.locIn(locData),
		.outValid(outValid),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== logic/bchPkg.sv ====
`default_nettype none

`include "bch_macros.svh"

package bchPkg;

	typedef logic [`BCH_N-1:0] codeword;
	typedef logic [1:0] errCount;
	typedef logic [2:0] locDegree;           // Can pass t on a failed decode.

	// ------------------------------------------------------------------------
	// Stage hand-over records.
	typedef struct packed {
		codeword rx;
		gfPkg::syndromeVec syn;
	} synResult;

	typedef struct packed {
		codeword rx;
		gfPkg::gfPoly locator;
		locDegree degree;
	} locResult;

	typedef struct packed {
		codeword word;
		errCount count;
		logic uncorrectable;
	} decResult;

	// ------------------------------------------------------------------------
	// FSM states.
	typedef enum logic [1:0] {
		locIdle,
		locDiscrepancy,
		locUpdate,
		locDone
	} locState;

	typedef enum logic [1:0] {
		chIdle,
		chSearch,
		chDone
	} chienState;

endpackage

`default_nettype wire

// ==== logic/bch_macros.svh ====
`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// Field width, GF(2^m).
`define BCH_M 4

// Code length, 2^m - 1.
`define BCH_N 15

// Correctable errors per codeword.
`define BCH_T 3

`endif

// ==== logic/chienSearch.sv ====
`default_nettype none

`include "bch_macros.svh"

module chienSearch (
	input logic clk,
	input logic reset,
	input logic locValid,
	input bchPkg::locResult locIn,
	output logic outValid,
	output bchPkg::decResult result
);
	import gfPkg::*;
	import bchPkg::*;

	localparam int idxW = $clog2(`BCH_N);

	chienState state;
	logic [idxW-1:0] pos;
	errCount roots;
	codeword rxWord;
	codeword errMask;
	locDegree degree;
	gfPoly term;                              // c_j * alpha^(j*q).
	gfPoly termIn;
	gfPoly termNext;
	gfElem evalSum;
	logic uncorrectable;

	// Load takes one alpha step too, so the search starts at bit 14.
	assign termIn = (state != chSearch) ? locIn.locator : term;
	assign termNext[0] = termIn[0];

	for (genvar j = 1; j <= `BCH_T; j++) begin : genTerm
		gfMultiplier stepMul (
			.a(termIn[j]),
			.b(alphaPow(j)),
			.product(termNext[j])
		);
	end

	always_comb begin
		evalSum = '0;
		for (int j = 0; j <= `BCH_T; j++) begin
			evalSum = evalSum ^ term[j];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= chIdle;
			pos <= '0;
			roots <= '0;
		end else begin
			case (state)
				chIdle, chDone: begin
					// The done cycle can already take the next locator.
					if (locValid) begin
						state <= chSearch;
						pos <= idxW'(`BCH_N - 1);
						roots <= '0;
					end else begin
						state <= chIdle;
					end
				end
				chSearch: begin
					if (evalSum == '0) begin
						roots <= roots + 1'b1;
					end
					if (pos == '0) begin
						state <= chDone;
					end else begin
						pos <= pos - 1'b1;
					end
				end
				default: state <= chIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state != chSearch && locValid) begin
			rxWord <= locIn.rx;
			degree <= locIn.degree;
			errMask <= '0;
			term <= termNext;
		end else if (state == chSearch) begin
			term <= termNext;
			if (evalSum == '0) begin
				errMask[pos] <= 1'b1;           // Root at alpha^-pos.
			end
		end
	end

	assign uncorrectable = ({1'b0, roots} != degree);
	assign outValid = (state == chDone);
	assign result = '{
		word: uncorrectable ? rxWord : rxWord ^ errMask,
		count: uncorrectable ? errCount'(0) : roots,
		uncorrectable: uncorrectable
	};

	// The locator never hands over while a search runs.
	idleCheck: assert property (@(posedge clk) disable iff (reset)
		locValid |-> state != chSearch
	) else $error("locValid while the Chien search is busy");

endmodule

`default_nettype wire

// ==== logic/errorLocator.sv ====
`default_nettype none

`include "bch_macros.svh"

module errorLocator (
	input logic clk,
	input logic reset,
	input logic synValid,
	input bchPkg::synResult synIn,
	output logic locValid,
	output bchPkg::locResult locOut
);
	import gfPkg::*;
	import bchPkg::*;

	locState state;
	logic [1:0] step;                         // Odd step r = 2 * step + 1.
	codeword word;
	syndromeVec syn;
	gfPoly lambda;                            // C(x).
	gfPoly corr;                              // B(x).
	gfElem dPrev;
	gfElem dCur;
	gfElem dSum;
	locDegree len;
	gfPoly synTerm;
	gfPoly discTerm;
	gfPoly lambdaScaled;
	gfPoly lambdaNext;
	gfElem [`BCH_T-1:0] corrScaled;
	logic lengthChange;

	// ------------------------------------------------------------------------
	// Discrepancy and update arithmetic.
	always_comb begin
		for (int j = 0; j <= `BCH_T; j++) begin
			if (2 * int'(step) >= j) begin
				synTerm[j] = syn[2 * int'(step) - j];   // S(r - j).
			end else begin
				synTerm[j] = '0;
			end
		end
	end

	for (genvar j = 0; j <= `BCH_T; j++) begin : genCoeff
		gfMultiplier discMul (
			.a(lambda[j]),
			.b(synTerm[j]),
			.product(discTerm[j])
		);
		gfMultiplier lambdaMul (
			.a(lambda[j]),
			.b(dPrev),
			.product(lambdaScaled[j])
		);
	end

	// Top B term would leave the register.
	for (genvar j = 0; j < `BCH_T; j++) begin : genCorr
		gfMultiplier corrMul (
			.a(corr[j]),
			.b(dCur),
			.product(corrScaled[j])
		);
	end

	always_comb begin
		dSum = '0;
		for (int j = 0; j <= `BCH_T; j++) begin
			dSum = dSum ^ discTerm[j];
		end
		// dp * C(x) + d * x * B(x).
		lambdaNext[0] = lambdaScaled[0];
		for (int j = 1; j <= `BCH_T; j++) begin
			lambdaNext[j] = lambdaScaled[j] ^ corrScaled[j-1];
		end
	end

	assign lengthChange = (dCur != '0) && (len <= {1'b0, step});

	// ------------------------------------------------------------------------
	// Control.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= locIdle;
			step <= '0;
		end else begin
			case (state)
				locIdle: begin
					if (synValid) begin
						state <= locDiscrepancy;
						step <= '0;
					end
				end
				locDiscrepancy: state <= locUpdate;
				locUpdate: begin
					step <= step + 1'b1;
					state <= (step == 2'(`BCH_T - 1)) ? locDone : locDiscrepancy;
				end
				default: state <= locIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == locIdle && synValid) begin
			word <= synIn.rx;
			syn <= synIn.syn;
			lambda <= gfPoly'(1);
			corr <= gfPoly'(1);
			dPrev <= gfElem'(1);
			len <= '0;
		end else if (state == locDiscrepancy) begin
			dCur <= dSum;
		end else if (state == locUpdate) begin
			lambda <= lambdaNext;
			if (lengthChange) begin
				corr <= {lambda[`BCH_T-1:0], gfElem'(0)};   // x * C(x).
				len <= {step, 1'b1} - len;
				dPrev <= dCur;
			end else begin
				corr <= {corr[`BCH_T-2:0], gfElem'(0), gfElem'(0)};
			end
		end
	end

	assign locValid = (state == locDone);
	assign locOut = '{rx: word, locator: lambda, degree: len};

	// A new syndrome set only ever meets an idle engine.
	idleCheck: assert property (@(posedge clk) disable iff (reset)
		synValid |-> state == locIdle
	) else $error("synValid while the locator is busy");

endmodule

`default_nettype wire

// ==== logic/gfMultiplier.sv ====
`default_nettype none

`include "bch_macros.svh"

module gfMultiplier (
	input gfPkg::gfElem a,
	input gfPkg::gfElem b,
	output gfPkg::gfElem product
);
	import gfPkg::*;

	gfElem acc;

	// MSB of b first, partial sum doubled each step.
	always_comb begin
		acc = '0;
		for (int k = `BCH_M - 1; k >= 0; k--) begin
			acc = gfMulX(acc);
			if (b[k]) begin
				acc = acc ^ a;
			end
		end
	end

	assign product = acc;

endmodule

`default_nettype wire

// ==== logic/gfPkg.sv ====
`default_nettype none

`include "bch_macros.svh"

package gfPkg;

	typedef logic [`BCH_M-1:0] gfElem;       // Polynomial basis.

	// Index j holds the x^j coefficient.
	typedef gfElem [`BCH_T:0] gfPoly;

	// S1 sits at index 0.
	typedef gfElem [2*`BCH_T-1:0] syndromeVec;

	// Low terms of x^4 + x + 1.
	localparam gfElem primPoly = gfElem'(3);

	// Times alpha, one shift and a conditional reduction.
	function automatic gfElem gfMulX(input gfElem v);
		return {v[`BCH_M-2:0], 1'b0} ^ (v[`BCH_M-1] ? primPoly : gfElem'(0));
	endfunction

	function automatic gfElem alphaPow(input int n);
		gfElem r;
		r = gfElem'(1);
		for (int k = 0; k < n; k++) begin
			r = gfMulX(r);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

// ==== logic/syndromeUnit.sv ====
`default_nettype none

`include "bch_macros.svh"

module syndromeUnit (
	input logic clk,
	input logic reset,
	input logic inValid,
	input bchPkg::codeword rxWord,
	output logic synValid,
	output bchPkg::synResult synOut
);
	import gfPkg::*;
	import bchPkg::*;

	localparam int idxW = $clog2(`BCH_N);

	codeword word;
	syndromeVec acc;
	syndromeVec accScaled;
	logic busy;
	logic [idxW-1:0] bitIdx;

	// Horner step, S_i scaled by alpha^i.
	for (genvar i = 0; i < 2 * `BCH_T; i++) begin : genHorner
		gfMultiplier scaleMul (
			.a(acc[i]),
			.b(alphaPow(i + 1)),
			.product(accScaled[i])
		);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			synValid <= 1'b0;
			bitIdx <= '0;
		end else begin
			synValid <= 1'b0;
			if (inValid) begin
				busy <= 1'b1;
				bitIdx <= idxW'(`BCH_N - 2);     // MSB goes in on the strobe.
			end else if (busy) begin
				if (bitIdx == '0) begin
					busy <= 1'b0;
					synValid <= 1'b1;
				end else begin
					bitIdx <= bitIdx - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			word <= rxWord;
			for (int i = 0; i < 2 * `BCH_T; i++) begin
				acc[i] <= gfElem'(rxWord[`BCH_N-1]);
			end
		end else if (busy) begin
			for (int i = 0; i < 2 * `BCH_T; i++) begin
				acc[i] <= accScaled[i] ^ gfElem'(word[bitIdx]);
			end
		end
	end

	assign synOut = '{rx: word, syn: acc};

	// Source keeps strobes at least N + 1 cycles apart.
	spacingCheck: assert property (@(posedge clk) disable iff (reset)
		inValid |=> !inValid [*`BCH_N]
	) else $error("inValid strobes closer than %0d cycles", `BCH_N + 1);

endmodule

`default_nettype wire

// ==== tests/bchDecoderTb.sv ====
`default_nettype none

module bchDecoderTb;
	import bchPkg::*;

	localparam int numCases = 18;
	localparam int latency = 15 + 7 + 16;       // Syndrome, locator, Chien.
	localparam int minSpacing = 16;             // Strobe to strobe, in cycles.
	localparam int cycleLimit = numCases * (23 + latency) + 100;

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	codeword rxWord;
	logic outValid;
	decResult result;

	logic [15:0] caseMem [0:4*numCases-1];     // Four fields per case.
	int pendingCase[$];
	int pendingCycle[$];
	int cycle = 0;
	int doneCount = 0;
	int seed = 48;

	bchDecoder u_dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.rxWord(rxWord),
		.outValid(outValid),
		.result(result)
	);

	always #20 clk = ~clk;

	// ------------------------------------------------------------------------
	// Error exit and compare tasks.
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string testName, input codeword expected,
			input codeword actual);
		if (actual !== expected) begin
			abortRun($sformatf("[FAIL] %s word: expected %h, actual %h",
				testName, expected, actual));
		end
	endtask

	task automatic checkCount(input string testName, input errCount expected,
			input errCount actual);
		if (actual !== expected) begin
			abortRun($sformatf("[FAIL] %s count: expected %0d, actual %0d",
				testName, expected, actual));
		end
	endtask

	task automatic checkFlag(input string testName, input bit expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("[FAIL] %s uncorrectable: expected %b, actual %b",
				testName, expected, actual));
		end
	endtask

	task automatic checkLatency(input string testName, input int expected, input int actual);
		if (actual != expected) begin
			abortRun($sformatf("[FAIL] %s latency: expected %0d, actual %0d",
				testName, expected, actual));
		end
	endtask

	// ------------------------------------------------------------------------
	// Cycle count and run limit.
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit) begin
			abortRun($sformatf("Timeout, run still going after %0d cycles", cycle));
		end
	end

	// Outputs are settled by the falling edge.
	always @(negedge clk) begin : watchOutputs
		int idx;
		int issued;
		string name;
		if (outValid === 1'b1) begin
			if (pendingCase.size() == 0) begin
				abortRun("outValid was raised with no word in flight");
			end else begin
				idx = pendingCase.pop_front();
				issued = pendingCycle.pop_front();
				name = $sformatf("case %0d", idx);
				checkLatency(name, latency, cycle - issued);
				checkWord(name, caseMem[4*idx+1][14:0], result.word);
				checkCount(name, caseMem[4*idx+2][1:0], result.count);
				checkFlag(name, caseMem[4*idx+3][0], result.uncorrectable);
				doneCount++;
			end
		end else if (outValid !== 1'b0) begin
			abortRun("outValid is neither high nor low");
		end else if (pendingCase.size() != 0 && cycle - pendingCycle[0] > latency) begin
			abortRun($sformatf("No result for case %0d within %0d cycles",
				pendingCase[0], latency));
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus.
	initial begin : driveCases
		int gap;
		reset = 1'b1;
		inValid = 1'b0;
		rxWord = '0;
		$readmemh("tests/bch_cases.txt", caseMem);
		for (int i = 0; i < 4 * numCases; i++) begin
			if ($isunknown(caseMem[i])) begin
				abortRun("The cases file is missing or has too few entries");
			end
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		for (int i = 0; i < numCases; i++) begin
			inValid = 1'b1;
			rxWord = caseMem[4*i][14:0];
			pendingCase.push_back(i);
			pendingCycle.push_back(cycle);
			// Cases 6 to 10 go in at the tightest spacing.
			if (i >= 6 && i <= 10) begin
				gap = minSpacing;
			end else begin
				gap = minSpacing + ($random(seed) & 7);
			end
			@(negedge clk);
			inValid = 1'b0;
			repeat (gap - 1) begin
				rxWord = codeword'($random(seed));   // Filler, not latched.
				@(negedge clk);
			end
		end

		while (pendingCase.size() != 0) begin
			@(negedge clk);
		end
		repeat (2 * latency) @(negedge clk);       // Room for a stray strobe.
		if (doneCount == numCases) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abortRun($sformatf("Got %0d results for %0d inputs", doneCount, numCases));
		end
	end

endmodule

`default_nettype wire

// ==== tests/bch_cases.txt ====
// Received word, expected corrected word, expected count, uncorrectable flag.
// All hex, one case per line, bit 14 is the first bit into the decoder.
0000 0000 0 0
0537 0537 0 0
7FFF 7FFF 0 0
5371 5370 1 0
4F59 0F59 1 0
56C7 5647 1 0
5B84 1B85 2 0
2BB0 29B8 2 0
7F9F 7FFF 2 0
45B6 0537 3 0
537E 5370 3 0
3400 0000 3 0
0649 0F59 3 0
6B85 1B85 3 0
000F 000F 0 1
7800 7800 0 1
537F 537F 0 1
0EB9 0EB9 0 1

// ==== vlog.f ====
+incdir+logic
logic/gfPkg.sv
logic/bchPkg.sv
logic/gfMultiplier.sv
logic/syndromeUnit.sv
logic/errorLocator.sv
logic/chienSearch.sv
logic/bchDecoder.sv
tests/bchDecoderTb.sv
